// File: rtl/wb_bridge_cfg.svh
// Wishbone bridge configuration: window decode, bus offsets and target constants
`ifndef WB_BRIDGE_CFG_SVH
`define WB_BRIDGE_CFG_SVH

// Upstream window seen from the management core
`define WB_UFP_BASE_ADDR    32'h3000_0000
`define WB_UFP_BASE_MASK    32'hFFF0_0000

// Offsets of the two downstream buses inside the window
`define WB_BUSA_OFFSET      32'h0000_0000
`define WB_BUSB_OFFSET      32'h000F_F800

// Base address each downstream bus presents to its target
`define WB_BUSA_BASE_ADDR   32'h3000_0000
`define WB_BUSB_BASE_ADDR   32'h0000_0000

// Bus B is narrow, 2 KiB of byte address space
`define WB_BUSB_ADDR_WIDTH  11

// Default depth of the bus B memory in 32-bit words
`define WB_SRAM_WORDS       512

// Value returned by the identification register
`define WB_REG_ID_VALUE     32'h5742_0A01

`endif

// File: rtl/wb_bus_pkg.sv
// Wishbone bus package: vector types shared by every bus port
`default_nettype none

`include "wb_bridge_cfg.svh"

package wb_bus_pkg;

    // Data word carried on every bus
    typedef logic [31:0] wb_data_t;

    // Full byte address of the upstream port and bus A
    typedef logic [31:0] wb_addr_t;

    // One select bit per byte lane
    typedef logic [3:0] wb_sel_t;

    // Byte address on the narrow bus B
    typedef logic [`WB_BUSB_ADDR_WIDTH-1:0] wb_busb_addr_t;

endpackage

`default_nettype wire

// File: rtl/periph_pkg.sv
// Peripheral package: register map and register field types of the bus A target
`default_nettype none

package periph_pkg;

    // Register index, taken from address bits 4 to 2
    typedef enum logic [2:0] {
        REG_ID      = 3'd0,
        REG_SCRATCH = 3'd1,
        REG_CTRL    = 3'd2,
        REG_COUNT   = 3'd3
    } reg_index_t;

    // Free-running cycle counter value
    typedef logic [31:0] count_t;

    // Count enable position in the control register
    localparam int unsigned CTRL_EN_BIT = 0;

    // Indexes 4 to 7 are left unused and read as zero

endpackage

`default_nettype wire

// File: rtl/wb_bridge_2way.sv
// Two-way Wishbone bridge: decodes the upstream window and routes cycles to bus A or bus B
`default_nettype none
`timescale 1ns/1ps

`include "wb_bridge_cfg.svh"

module wb_bridge_2way (
    // Only sampled by the assertions
    input  wire                            wb_clk_i,

    // Upstream port
    input  wire                            wbs_stb_i,
    input  wire                            wbs_cyc_i,
    input  wire                            wbs_we_i,
    input  wire wb_bus_pkg::wb_sel_t       wbs_sel_i,
    input  wire wb_bus_pkg::wb_data_t      wbs_dat_i,
    input  wire wb_bus_pkg::wb_addr_t      wbs_adr_i,
    output wire                            wbs_ack_o,
    output wire wb_bus_pkg::wb_data_t      wbs_dat_o,

    // Bus A
    output wire                            wbm_a_stb_o,
    output wire                            wbm_a_cyc_o,
    output wire                            wbm_a_we_o,
    output wire wb_bus_pkg::wb_sel_t       wbm_a_sel_o,
    output wire wb_bus_pkg::wb_data_t      wbm_a_dat_o,
    output wire wb_bus_pkg::wb_addr_t      wbm_a_adr_o,
    input  wire wb_bus_pkg::wb_data_t      wbm_a_dat_i,
    input  wire                            wbm_a_ack_i,

    // Bus B
    output wire                            wbm_b_stb_o,
    output wire                            wbm_b_cyc_o,
    output wire                            wbm_b_we_o,
    output wire wb_bus_pkg::wb_sel_t       wbm_b_sel_o,
    output wire wb_bus_pkg::wb_data_t      wbm_b_dat_o,
    output wire wb_bus_pkg::wb_busb_addr_t wbm_b_adr_o,
    input  wire wb_bus_pkg::wb_data_t      wbm_b_dat_i,
    input  wire                            wbm_b_ack_i
);

    import wb_bus_pkg::*;

    logic     win_sel;
    logic     hit_b;
    logic     sel_a;
    logic     sel_b;
    wb_addr_t win_offset;
    wb_addr_t addr_a;
    wb_addr_t addr_b;

    // Window hit and offset inside the window
    assign win_sel    = (wbs_adr_i & `WB_UFP_BASE_MASK) == `WB_UFP_BASE_ADDR;
    assign win_offset = wbs_adr_i & ~`WB_UFP_BASE_MASK;

    // Top 2 KiB of the window belong to bus B
    assign hit_b = win_offset >= `WB_BUSB_OFFSET;
    assign sel_a = win_sel & ~hit_b;
    assign sel_b = win_sel & hit_b;

    assign addr_a = win_offset - `WB_BUSA_OFFSET + `WB_BUSA_BASE_ADDR;
    assign addr_b = win_offset - `WB_BUSB_OFFSET + `WB_BUSB_BASE_ADDR;

    assign wbm_a_stb_o = wbs_stb_i & sel_a;
    assign wbm_a_cyc_o = wbs_cyc_i;
    assign wbm_a_we_o  = wbs_we_i & sel_a;
    assign wbm_a_sel_o = wbs_sel_i & {4{sel_a}};
    assign wbm_a_dat_o = wbs_dat_i & {32{sel_a}};
    assign wbm_a_adr_o = addr_a;

    assign wbm_b_stb_o = wbs_stb_i & sel_b;
    assign wbm_b_cyc_o = wbs_cyc_i;
    assign wbm_b_we_o  = wbs_we_i & sel_b;
    assign wbm_b_sel_o = wbs_sel_i & {4{sel_b}};
    assign wbm_b_dat_o = wbs_dat_i & {32{sel_b}};
    assign wbm_b_adr_o = addr_b[`WB_BUSB_ADDR_WIDTH-1:0];

    // Response from the selected bus only, zero outside the window
    assign wbs_ack_o = (wbm_a_ack_i & sel_a) | (wbm_b_ack_i & sel_b);
    assign wbs_dat_o = (wbm_a_dat_i & {32{sel_a}}) | (wbm_b_dat_i & {32{sel_b}});

    // Never both targets answering at once
    a_one_ack: assert property (@(posedge wb_clk_i) !(wbm_a_ack_i && wbm_b_ack_i));

    // An upstream ack answers the strobe of the cycle before
    a_ack_after_stb: assert property (@(posedge wb_clk_i)
        wbs_ack_o |-> $past(wbs_stb_i && wbs_cyc_i));

endmodule

`default_nettype wire

// File: rtl/wb_reg_bank.sv
// Register bank on bus A: identification, scratch, control and cycle counter registers
`default_nettype none
`timescale 1ns/1ps

`include "wb_bridge_cfg.svh"

module wb_reg_bank (
    input  wire                       wb_clk_i,
    input  wire                       rst_n_i,
    input  wire                       wb_stb_i,
    input  wire                       wb_cyc_i,
    input  wire                       wb_we_i,
    input  wire wb_bus_pkg::wb_sel_t  wb_sel_i,
    input  wire wb_bus_pkg::wb_data_t wb_dat_i,
    input  wire wb_bus_pkg::wb_addr_t wb_adr_i,
    output logic                      wb_ack_o,
    output wb_bus_pkg::wb_data_t      wb_dat_o
);

    import wb_bus_pkg::*;
    import periph_pkg::*;

    logic       access;
    logic       wr_fire;
    logic       count_en;
    reg_index_t reg_idx;
    wb_data_t   scratch;
    wb_data_t   rd_data;
    count_t     count;

    // Higher address bits alias onto the eight slots
    assign reg_idx = reg_index_t'(wb_adr_i[4:2]);

    // One access per strobe, the cycle after ack is idle
    assign access  = wb_stb_i & wb_cyc_i & ~wb_ack_o;
    assign wr_fire = access & wb_we_i;

    always_ff @(posedge wb_clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            wb_ack_o <= 1'b0;
        end else begin
            wb_ack_o <= access;
        end
    end

    always_ff @(posedge wb_clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            scratch  <= '0;
            count_en <= 1'b0;
        end else if (wr_fire) begin
            if (reg_idx == REG_SCRATCH) begin
                for (int b = 0; b < 4; b++) begin
                    if (wb_sel_i[b]) begin
                        scratch[8*b +: 8] <= wb_dat_i[8*b +: 8];
                    end
                end
            end
            if (reg_idx == REG_CTRL && wb_sel_i[0]) begin
                count_en <= wb_dat_i[CTRL_EN_BIT];
            end
        end
    end

    // Any write to the counter clears it, otherwise it runs while enabled
    always_ff @(posedge wb_clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            count <= '0;
        end else if (wr_fire && reg_idx == REG_COUNT) begin
            count <= '0;
        end else if (count_en) begin
            count <= count + 1'b1;
        end
    end

    always_comb begin
        rd_data = '0;
        case (reg_idx)
            REG_ID:      rd_data = `WB_REG_ID_VALUE;
            REG_SCRATCH: rd_data = scratch;
            REG_CTRL:    rd_data[CTRL_EN_BIT] = count_en;
            REG_COUNT:   rd_data = count;
            default:     rd_data = '0;
        endcase
    end

    // Read data captured on the edge that raises ack
    always_ff @(posedge wb_clk_i) begin
        if (access) begin
            wb_dat_o <= rd_data;
        end
    end

    // Master keeps the cycle open for the whole strobe
    a_stb_in_cyc: assert property (@(posedge wb_clk_i) disable iff (!rst_n_i)
        wb_stb_i |-> wb_cyc_i);

endmodule

`default_nettype wire

// File: rtl/wb_sram.sv
// Word memory on bus B with byte-lane writes and a registered one-cycle acknowledge
`default_nettype none
`timescale 1ns/1ps

`include "wb_bridge_cfg.svh"

module wb_sram #(
    parameter int unsigned WORDS = `WB_SRAM_WORDS
) (
    input  wire                            wb_clk_i,
    input  wire                            rst_n_i,
    input  wire                            wb_stb_i,
    input  wire                            wb_cyc_i,
    input  wire                            wb_we_i,
    input  wire wb_bus_pkg::wb_sel_t       wb_sel_i,
    input  wire wb_bus_pkg::wb_data_t      wb_dat_i,
    input  wire wb_bus_pkg::wb_busb_addr_t wb_adr_i,
    output logic                           wb_ack_o,
    output wb_bus_pkg::wb_data_t           wb_dat_o
);

    import wb_bus_pkg::*;

    localparam int unsigned IDX_W = $clog2(WORDS);

    logic             access;
    logic [IDX_W-1:0] word_idx;
    wb_data_t         mem [WORDS];

    // Word index from the byte address, bits 10 to 2 at the default depth
    assign word_idx = wb_adr_i[IDX_W+1:2];
    assign access   = wb_stb_i & wb_cyc_i & ~wb_ack_o;

    always_ff @(posedge wb_clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            wb_ack_o <= 1'b0;
        end else begin
            wb_ack_o <= access;
        end
    end

    always_ff @(posedge wb_clk_i) begin
        if (access) begin
            if (wb_we_i) begin
                for (int b = 0; b < 4; b++) begin
                    if (wb_sel_i[b]) begin
                        mem[word_idx][8*b +: 8] <= wb_dat_i[8*b +: 8];
                    end
                end
            end
            // Old contents on a write, the word itself on a read
            wb_dat_o <= mem[word_idx];
        end
    end

    // Master keeps the cycle open for the whole strobe
    a_stb_in_cyc: assert property (@(posedge wb_clk_i) disable iff (!rst_n_i)
        wb_stb_i |-> wb_cyc_i);

endmodule

`default_nettype wire

// File: rtl/user_wb_top.sv
// User-area top: upstream Wishbone port, two-way bridge, register bank and memory
`default_nettype none
`timescale 1ns/1ps

module user_wb_top (
    input  wire                       wb_clk_i,
    input  wire                       rst_n_i,
    input  wire                       wbs_stb_i,
    input  wire                       wbs_cyc_i,
    input  wire                       wbs_we_i,
    input  wire wb_bus_pkg::wb_sel_t  wbs_sel_i,
    input  wire wb_bus_pkg::wb_data_t wbs_dat_i,
    input  wire wb_bus_pkg::wb_addr_t wbs_adr_i,
    output wire                       wbs_ack_o,
    output wire wb_bus_pkg::wb_data_t wbs_dat_o
);

    import wb_bus_pkg::*;

    // Bus A, bridge to register bank
    logic          wbm_a_stb;
    logic          wbm_a_cyc;
    logic          wbm_a_we;
    wb_sel_t       wbm_a_sel;
    wb_data_t      wbm_a_dat;
    wb_addr_t      wbm_a_adr;
    wb_data_t      wbm_a_rdat;
    logic          wbm_a_ack;

    // Bus B, bridge to memory
    logic          wbm_b_stb;
    logic          wbm_b_cyc;
    logic          wbm_b_we;
    wb_sel_t       wbm_b_sel;
    wb_data_t      wbm_b_dat;
    wb_busb_addr_t wbm_b_adr;
    wb_data_t      wbm_b_rdat;
    logic          wbm_b_ack;

    wb_bridge_2way u_bridge (
        .wb_clk_i    (wb_clk_i),
        .wbs_stb_i   (wbs_stb_i),
        .wbs_cyc_i   (wbs_cyc_i),
        .wbs_we_i    (wbs_we_i),
        .wbs_sel_i   (wbs_sel_i),
        .wbs_dat_i   (wbs_dat_i),
        .wbs_adr_i   (wbs_adr_i),
        .wbs_ack_o   (wbs_ack_o),
        .wbs_dat_o   (wbs_dat_o),
        .wbm_a_stb_o (wbm_a_stb),
        .wbm_a_cyc_o (wbm_a_cyc),
        .wbm_a_we_o  (wbm_a_we),
        .wbm_a_sel_o (wbm_a_sel),
        .wbm_a_dat_o (wbm_a_dat),
        .wbm_a_adr_o (wbm_a_adr),
        .wbm_a_dat_i (wbm_a_rdat),
        .wbm_a_ack_i (wbm_a_ack),
        .wbm_b_stb_o (wbm_b_stb),
        .wbm_b_cyc_o (wbm_b_cyc),
        .wbm_b_we_o  (wbm_b_we),
        .wbm_b_sel_o (wbm_b_sel),
        .wbm_b_dat_o (wbm_b_dat),
        .wbm_b_adr_o (wbm_b_adr),
        .wbm_b_dat_i (wbm_b_rdat),
        .wbm_b_ack_i (wbm_b_ack)
    );

    wb_reg_bank u_regs (
        .wb_clk_i (wb_clk_i),
        .rst_n_i  (rst_n_i),
        .wb_stb_i (wbm_a_stb),
        .wb_cyc_i (wbm_a_cyc),
        .wb_we_i  (wbm_a_we),
        .wb_sel_i (wbm_a_sel),
        .wb_dat_i (wbm_a_dat),
        .wb_adr_i (wbm_a_adr),
        .wb_ack_o (wbm_a_ack),
        .wb_dat_o (wbm_a_rdat)
    );

    wb_sram u_sram (
        .wb_clk_i (wb_clk_i),
        .rst_n_i  (rst_n_i),
        .wb_stb_i (wbm_b_stb),
        .wb_cyc_i (wbm_b_cyc),
        .wb_we_i  (wbm_b_we),
        .wb_sel_i (wbm_b_sel),
        .wb_dat_i (wbm_b_dat),
        .wb_adr_i (wbm_b_adr),
        .wb_ack_o (wbm_b_ack),
        .wb_dat_o (wbm_b_rdat)
    );

endmodule

`default_nettype wire

// File: bench/tb_user_wb.sv
// Directed testbench for the user-area Wishbone subsystem with register bank and memory
`default_nettype none
`timescale 1ns/1ps

`include "wb_bridge_cfg.svh"

module tb_user_wb;

    import wb_bus_pkg::*;

    localparam int MAX_CYCLES = 4000;
    localparam wb_addr_t REG_BASE = `WB_UFP_BASE_ADDR + `WB_BUSA_OFFSET;
    localparam wb_addr_t MEM_BASE = `WB_UFP_BASE_ADDR + `WB_BUSB_OFFSET;

    logic     clk;
    logic     rst_n;
    logic     wbs_stb;
    logic     wbs_cyc;
    logic     wbs_we;
    wb_sel_t  wbs_sel;
    wb_data_t wbs_dat;
    wb_addr_t wbs_adr;
    wire      wbs_ack;
    wb_data_t wbs_rdat;

    int          errors;
    int          checks;
    int          test_errors;
    int          cycle_count;
    logic [31:0] rng_state;
    wb_data_t    mem_model [`WB_SRAM_WORDS];
    wb_sel_t     mem_known [`WB_SRAM_WORDS];

    user_wb_top uut (
        .wb_clk_i  (clk),
        .rst_n_i   (rst_n),
        .wbs_stb_i (wbs_stb),
        .wbs_cyc_i (wbs_cyc),
        .wbs_we_i  (wbs_we),
        .wbs_sel_i (wbs_sel),
        .wbs_dat_i (wbs_dat),
        .wbs_adr_i (wbs_adr),
        .wbs_ack_o (wbs_ack),
        .wbs_dat_o (wbs_rdat)
    );

    initial clk = 1'b0;
    always #5 clk = ~clk;

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count >= MAX_CYCLES) begin
            $display("Run stopped after %0d cycles without finishing", MAX_CYCLES);
            $display("STATUS: FAIL");
            $finish;
        end
    end

    // LCG step, callers take the upper bits that vary most
    function automatic logic [31:0] next_random();
        rng_state = rng_state * 32'd1664525 + 32'd1013904223;
        return rng_state;
    endfunction

    function automatic wb_data_t lane_mask(input wb_sel_t sel);
        return {{8{sel[3]}}, {8{sel[2]}}, {8{sel[1]}}, {8{sel[0]}}};
    endfunction

    function automatic wb_data_t merge_lanes(input wb_data_t old, input wb_data_t nw,
                                             input wb_sel_t sel);
        return (old & ~lane_mask(sel)) | (nw & lane_mask(sel));
    endfunction

    task automatic check_value(input string name, input wb_data_t exp, input wb_data_t act);
        checks++;
        assert (act === exp) else begin
            $display("ERROR %0t ns: %s expected %h, got %h", $time, name, exp, act);
            errors++;
        end
    endtask

    // One classic cycle, called and returning on a falling edge
    task automatic bus_access(input wb_addr_t adr, input logic we, input wb_data_t dat,
                              input wb_sel_t sel, output wb_data_t rdat);
        int waited;
        waited  = 0;
        wbs_adr = adr;
        wbs_we  = we;
        wbs_dat = dat;
        wbs_sel = sel;
        wbs_stb = 1'b1;
        wbs_cyc = 1'b1;
        do begin
            @(negedge clk);
            waited++;
        end while (!wbs_ack && waited < 4);
        checks++;
        assert (wbs_ack) else begin
            $display("No acknowledge within 4 cycles for address %h at %0t ns", adr, $time);
            errors++;
        end
        rdat    = wbs_rdat;
        wbs_stb = 1'b0;
        wbs_cyc = 1'b0;
        wbs_we  = 1'b0;
    endtask

    task automatic wb_write(input wb_addr_t adr, input wb_data_t dat, input wb_sel_t sel);
        wb_data_t unused;
        bus_access(adr, 1'b1, dat, sel, unused);
    endtask

    task automatic wb_read(input wb_addr_t adr, output wb_data_t dat);
        bus_access(adr, 1'b0, '0, 4'hF, dat);
    endtask

    task automatic wb_read_no_ack(input wb_addr_t adr);
        logic saw_ack;
        saw_ack = 1'b0;
        wbs_adr = adr;
        wbs_sel = 4'hF;
        wbs_stb = 1'b1;
        wbs_cyc = 1'b1;
        repeat (8) begin
            @(negedge clk);
            saw_ack = saw_ack | wbs_ack;
            check_value("wbs_dat_o", '0, wbs_rdat);
        end
        checks++;
        assert (!saw_ack) else begin
            $display("Address %h outside the window was acknowledged", adr);
            errors++;
        end
        wbs_stb = 1'b0;
        wbs_cyc = 1'b0;
    endtask

    task automatic finish_test(input string name);
        $display("Test %s finished with %0d errors", name, errors - test_errors);
        test_errors = errors;
    endtask

    task automatic reset_and_id();
        wb_data_t rd;
        wb_read(REG_BASE + 32'h0, rd);
        check_value("wbs_dat_o (id)", `WB_REG_ID_VALUE, rd);
        for (int i = 1; i < 4; i++) begin
            wb_read(REG_BASE + 4 * i, rd);
            check_value("wbs_dat_o (reset value)", '0, rd);
        end
        wb_write(REG_BASE + 32'h0, 32'hFFFF_FFFF, 4'hF);
        wb_read(REG_BASE + 32'h0, rd);
        check_value("wbs_dat_o (id after write)", `WB_REG_ID_VALUE, rd);
        finish_test("reset_id");
    endtask

    task automatic scratch_bytes();
        wb_data_t rd;
        wb_data_t model;
        wb_data_t dat;
        wb_sel_t  sel;
        model = 32'hA5C3_1E77;
        wb_write(REG_BASE + 32'h4, model, 4'hF);
        wb_read(REG_BASE + 32'h4, rd);
        check_value("wbs_dat_o (scratch)", model, rd);
        for (int i = 0; i < 8; i++) begin
            dat = next_random();
            sel = (i == 0) ? 4'hF : next_random() >> 28;
            model = merge_lanes(model, dat, sel);
            wb_write(REG_BASE + 32'h4, dat, sel);
            wb_read(REG_BASE + 32'h4, rd);
            check_value("wbs_dat_o (scratch)", model, rd);
        end
        finish_test("scratch");
    endtask

    task automatic counter_run();
        wb_data_t c1;
        wb_data_t c2;
        wb_data_t rd;
        wb_write(REG_BASE + 32'h8, 32'h1, 4'hF);
        wb_read(REG_BASE + 32'h8, rd);
        check_value("wbs_dat_o (ctrl)", 32'h1, rd);
        wb_read(REG_BASE + 32'hC, c1);
        wb_read(REG_BASE + 32'hC, c2);
        checks++;
        assert (c2 > c1) else begin
            $display("ERROR %0t ns: count not increasing, first %h, then %h", $time, c1, c2);
            errors++;
        end
        wb_write(REG_BASE + 32'h8, 32'h0, 4'hF);
        wb_read(REG_BASE + 32'hC, c1);
        wb_read(REG_BASE + 32'hC, c2);
        check_value("wbs_dat_o (count stopped)", c1, c2);
        wb_write(REG_BASE + 32'hC, 32'h1234, 4'hF);
        wb_read(REG_BASE + 32'hC, rd);
        checks++;
        assert (rd < c2) else begin
            $display("ERROR %0t ns: count after write %h not below %h", $time, rd, c2);
            errors++;
        end
        finish_test("counter");
    endtask

    task automatic memory_bus_b();
        wb_addr_t addr_q [$];
        wb_addr_t adr;
        wb_data_t dat;
        wb_data_t rd;
        wb_sel_t  sel;
        int       idx;
        for (int i = 0; i < 40; i++) begin
            idx = (i == 0) ? 0 : (i == 1) ? `WB_SRAM_WORDS - 1 : next_random() >> 23;
            sel = (i < 2) ? 4'hF : next_random() >> 28;
            dat = next_random();
            adr = MEM_BASE + 4 * idx;
            mem_model[idx] = merge_lanes(mem_model[idx], dat, sel);
            mem_known[idx] = mem_known[idx] | sel;
            addr_q.push_back(adr);
            wb_write(adr, dat, sel);
        end
        foreach (addr_q[i]) begin
            idx = (addr_q[i] - MEM_BASE) >> 2;
            wb_read(addr_q[i], rd);
            // Bytes never written stay unknown and are left out
            check_value("wbs_dat_o (memory)", mem_model[idx] & lane_mask(mem_known[idx]),
                        rd & lane_mask(mem_known[idx]));
        end
        finish_test("memory");
    endtask

    task automatic decode_bounds();
        wb_data_t rd;
        wb_read(`WB_UFP_BASE_ADDR + 32'h000F_F7FC, rd);
        check_value("wbs_dat_o (index 7)", '0, rd);
        wb_write(REG_BASE + 32'h4, 32'h3C5A_9612, 4'hF);
        wb_read(REG_BASE + 32'h24, rd);
        check_value("wbs_dat_o (scratch alias)", 32'h3C5A_9612, rd);
        wb_read_no_ack(32'h2000_0000);
        finish_test("decode");
    endtask

    initial begin
        errors      = 0;
        checks      = 0;
        test_errors = 0;
        cycle_count = 0;
        rng_state   = 32'hb2249726;
        for (int i = 0; i < `WB_SRAM_WORDS; i++) begin
            mem_model[i] = '0;
            mem_known[i] = '0;
        end
        rst_n   = 1'b0;
        wbs_stb = 1'b0;
        wbs_cyc = 1'b0;
        wbs_we  = 1'b0;
        wbs_sel = '0;
        wbs_dat = '0;
        wbs_adr = '0;
        repeat (5) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        @(negedge clk);
        reset_and_id();
        scratch_bytes();
        counter_run();
        memory_bus_b();
        decode_bounds();
        $display("Summary: 5 tests, %0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: files.f
+incdir+rtl
rtl/wb_bus_pkg.sv
rtl/periph_pkg.sv
rtl/wb_bridge_2way.sv
rtl/wb_reg_bank.sv
rtl/wb_sram.sv
rtl/user_wb_top.sv
bench/tb_user_wb.sv

// File: Bender.yml
package:
  name: user_wb

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/wb_bus_pkg.sv
      - rtl/periph_pkg.sv
      - rtl/wb_bridge_2way.sv
      - rtl/wb_reg_bank.sv
      - rtl/wb_sram.sv
      - rtl/user_wb_top.sv
  - target: test
    include_dirs:
      - rtl
    files:
      - bench/tb_user_wb.sv
